//--- rtl/s16b_pkg.sv
// ------------------------------
// S16B main board bus types
// Region names, CPU bus, chip
// selects, cabinet inputs and the
// mapper reset table
// ------------------------------
package s16b_pkg;

    // Mapper regions, lowest index wins
    typedef enum logic [2:0] {
        REG_ROM0,
        REG_ROM1,
        REG_ROM2,
        REG_RAM,
        REG_VRAM,
        REG_ORAM,
        REG_PAL,
        REG_IO
    } s16b_region_e;

    // 68000 side of the board
    typedef struct packed {
        logic [23:1] addr;
        logic [15:0] dout;   // CPU write data
        logic        rnw;
        logic        udsn;
        logic        ldsn;
        logic        asn;
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;   // tile RAM
        logic chr;    // text RAM
        logic pal;
        logic obj;
        logic io;
        logic map;
    } cs_t;

    typedef struct packed {
        logic [7:0] joystick1;
        logic [7:0] joystick2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic       test;
        logic [7:0] dip_a;
        logic [7:0] dip_b;
    } cab_in_t;

    // Address bits 23:16 of the mapper registers
    localparam logic [7:0] MAP_PAGE = 8'hff;

    // Only region 0 is live out of reset, covering 0x000000-0x07ffff
    localparam logic [7:0] MAP_BASE_RST [8] = '{
        8'h00, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff
    };
    localparam logic [7:0] MAP_MASK_RST [8] = '{
        8'hf8, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff
    };

endpackage

//--- rtl/s16b_mapper.sv
// ------------------------------
// S16B memory mapper
// Eight base/mask pairs written by
// the CPU, priority region flags
// ------------------------------
module s16b_mapper (
    input  logic               clk,
    input  logic               rst,
    input  s16b_pkg::cpu_bus_t bus,
    output logic [7:0]         active
);

    logic [7:0] base [8];
    logic [7:0] mask [8];
    logic [7:0] page;
    logic       map_page;
    logic       map_we;
    logic [7:0] hit;

    assign page     = bus.addr[23:16];
    assign map_page = page == s16b_pkg::MAP_PAGE;
    // Register writes only use the low byte
    assign map_we   = map_page && !bus.asn && !bus.rnw && !bus.ldsn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                base[i] <= s16b_pkg::MAP_BASE_RST[i];
                mask[i] <= s16b_pkg::MAP_MASK_RST[i];
            end
        end else if (map_we) begin
            // Odd register index selects the mask
            if (bus.addr[1]) begin
                mask[bus.addr[4:2]] <= bus.dout[7:0];
            end else begin
                base[bus.addr[4:2]] <= bus.dout[7:0];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            hit[i] = ((page ^ base[i]) & mask[i]) == 8'h00;
        end
    end

    // Two's complement isolates the lowest region that hits
    always_comb begin
        active = 8'h00;
        if (!map_page) begin
            active = hit & (~hit + 8'h01);
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(active))
        else $error("mapper flags more than one region");

endmodule

//--- rtl/s16b_bus_decode.sv
// ------------------------------
// S16B bus decoder
// Registered chip selects from the
// mapper flags and bus strobes
// ------------------------------
module s16b_bus_decode (
    input  logic               clk,
    input  logic               rst,
    input  s16b_pkg::cpu_bus_t bus,
    input  logic [7:0]         active,
    output s16b_pkg::cs_t      cs
);

    logic ds_low;
    logic map_page;
    logic rom_hit;

    // Either data strobe asserted
    assign ds_low   = !(bus.udsn && bus.ldsn);
    assign map_page = bus.addr[23:16] == s16b_pkg::MAP_PAGE;
    assign rom_hit  = active[s16b_pkg::REG_ROM0]
                   || active[s16b_pkg::REG_ROM1]
                   || active[s16b_pkg::REG_ROM2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= '0;
        end else if (!bus.asn) begin
            cs.rom  <= rom_hit;
            // RAM selects follow the data strobes so that
            // each half of a read-modify-write is a new request
            cs.ram  <= ds_low && active[s16b_pkg::REG_RAM];
            cs.vram <= ds_low && active[s16b_pkg::REG_VRAM] && !bus.addr[16];
            // Text RAM sits in the upper half of the VRAM region
            cs.chr  <= active[s16b_pkg::REG_VRAM] && bus.addr[16];
            cs.obj  <= active[s16b_pkg::REG_ORAM];
            cs.pal  <= active[s16b_pkg::REG_PAL];
            cs.io   <= active[s16b_pkg::REG_IO];
            cs.map  <= map_page;
        end else begin
            cs <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(cs))
        else $error("more than one chip select high");

endmodule

//--- rtl/s16b_cab_io.sv
// ------------------------------
// S16B cabinet I/O
// Screen flip latch, joystick and
// DIP switch reads
// ------------------------------
module s16b_cab_io (
    input  logic               clk,
    input  logic               rst,
    input  s16b_pkg::cpu_bus_t bus,
    input  logic               io_cs,
    input  s16b_pkg::cab_in_t  cab,
    output logic [7:0]         cab_dout,
    output logic               flip
);

    logic [7:0] sys_byte;
    logic [7:0] joy1_sorted;
    logic [7:0] joy2_sorted;

    // Board wiring of the joystick bits
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        return {joy[1], joy[0], joy[3], joy[2], joy[7], joy[5], joy[4], joy[6]};
    endfunction

    assign joy1_sorted = sort_joy(cab.joystick1);
    assign joy2_sorted = sort_joy(cab.joystick2);
    assign sys_byte    = {2'b11, cab.start[1], cab.start[0], cab.service, cab.test,
                          cab.coin[1], cab.coin[0]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip <= 1'b0;
        end else if (io_cs && bus.addr[13:12] == 2'd0 && !bus.rnw && !bus.ldsn) begin
            flip <= bus.dout[6];
        end
    end

    always_ff @(posedge clk) begin
        cab_dout <= 8'hff;
        if (io_cs && bus.rnw) begin
            case (bus.addr[13:12])
                2'd1: begin
                    case (bus.addr[2:1])
                        2'd0: cab_dout <= sys_byte;
                        2'd1: cab_dout <= joy1_sorted;
                        2'd3: cab_dout <= joy2_sorted;
                        default: cab_dout <= 8'hff;
                    endcase
                end
                2'd2: cab_dout <= bus.addr[1] ? cab.dip_b : cab.dip_a;
                default: cab_dout <= 8'hff;
            endcase
        end
    end

endmodule

//--- rtl/s16b_dtack.sv
// ------------------------------
// S16B DTACK generator
// Fractional CPU clock enables and
// DTACK with memory wait states
// ------------------------------
module s16b_dtack #(
    parameter logic [7:0] CEN_NUM = 8'd29,
    parameter logic [7:0] CEN_DEN = 8'd146
) (
    input  logic               clk,
    input  logic               rst,
    input  s16b_pkg::cpu_bus_t bus,
    input  s16b_pkg::cs_t      cs,
    input  logic               rom_ok,
    input  logic               ram_ok,
    output logic               cpu_cen,
    output logic               cpu_cenb,
    output logic               dtackn
);

    typedef enum logic [1:0] {IDLE, WAIT, ACK} state_e;

    localparam logic [15:0] NUM  = {8'h00, CEN_NUM};
    localparam logic [15:0] DEN  = {8'h00, CEN_DEN};
    localparam logic [15:0] HALF = {9'h000, CEN_DEN[7:1]};

    logic [15:0] acc;
    logic [15:0] acc_sum;
    logic        wrap;
    logic        busy;
    logic        ds_low;
    state_e      state;

    assign acc_sum = acc + NUM;
    assign wrap    = acc_sum >= DEN;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc      <= 16'h0000;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            acc      <= wrap ? acc_sum - DEN : acc_sum;
            cpu_cen  <= wrap;
            // Second phase fires when the count crosses mid period
            cpu_cenb <= acc < HALF && acc_sum >= HALF;
        end
    end

    // Slow memories hold the cycle until ok
    assign busy   = (cs.rom && !rom_ok) || ((cs.ram || cs.vram) && !ram_ok);
    assign ds_low = !(bus.udsn && bus.ldsn);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else if (bus.asn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (ds_low) state <= WAIT;
                WAIT: if (cpu_cen && !busy) state <= ACK;
                default: state <= ACK;
            endcase
        end
    end

    assign dtackn = state != ACK;

    assert property (@(posedge clk) disable iff (rst) $fell(dtackn) |-> !bus.asn)
        else $error("dtackn fell without an address strobe");

endmodule

//--- rtl/s16b_main.sv
// ------------------------------
// S16B main CPU bus subsystem
// Mapper, decoder, cabinet I/O,
// DTACK and read data mux
// ------------------------------
module s16b_main #(
    parameter logic [7:0] CEN_NUM = 8'd29,
    parameter logic [7:0] CEN_DEN = 8'd146
) (
    input  logic               clk,
    input  logic               rst,
    input  s16b_pkg::cpu_bus_t bus,
    input  s16b_pkg::cab_in_t  cab,
    input  logic [15:0]        rom_data,
    input  logic               rom_ok,
    input  logic [15:0]        ram_data,
    input  logic               ram_ok,
    input  logic [15:0]        char_dout,
    input  logic [15:0]        pal_dout,
    input  logic [15:0]        obj_dout,
    output s16b_pkg::cs_t      cs,
    output logic [15:0]        cpu_din,
    output logic               dtackn,
    output logic               cpu_cen,
    output logic               cpu_cenb,
    output logic               flip
);

    logic [7:0] active;
    logic [7:0] cab_dout;

    s16b_mapper u_mapper (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .active (active)
    );

    s16b_bus_decode u_bus_decode (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .active (active),
        .cs     (cs)
    );

    s16b_cab_io u_cab_io (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .io_cs    (cs.io),
        .cab      (cab),
        .cab_dout (cab_dout),
        .flip     (flip)
    );

    s16b_dtack #(
        .CEN_NUM (CEN_NUM),
        .CEN_DEN (CEN_DEN)
    ) u_dtack (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .cs       (cs),
        .rom_ok   (rom_ok),
        .ram_ok   (ram_ok),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb),
        .dtackn   (dtackn)
    );

    // Read data, first select in priority order wins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 16'hffff;
        end else if (cs.ram || cs.vram) begin
            cpu_din <= ram_data;
        end else if (cs.rom) begin
            cpu_din <= rom_data;
        end else if (cs.chr) begin
            cpu_din <= char_dout;
        end else if (cs.pal) begin
            cpu_din <= pal_dout;
        end else if (cs.obj) begin
            cpu_din <= obj_dout;
        end else if (cs.io) begin
            cpu_din <= {8'hff, cab_dout};
        end
        // Unmapped cycles keep the last value
    end

endmodule

//--- sim/s16b_main_tb.sv
// ------------------------------
// S16B main bus testbench
// Plays the 68000 and the memories,
// runs the stim file tests and
// checks data, selects, flip, enables
// ------------------------------
module s16b_main_tb;

    localparam logic [7:0] CEN_NUM = 8'd29;
    localparam logic [7:0] CEN_DEN = 8'd146;

    logic               clk;
    logic               rst;
    s16b_pkg::cpu_bus_t bus;
    s16b_pkg::cab_in_t  cab;
    logic [15:0]        rom_data;
    logic               rom_ok;
    logic [15:0]        ram_data;
    logic               ram_ok;
    logic [15:0]        char_dout;
    logic [15:0]        pal_dout;
    logic [15:0]        obj_dout;
    s16b_pkg::cs_t      cs;
    logic [15:0]        cpu_din;
    logic               dtackn;
    logic               cpu_cen;
    logic               cpu_cenb;
    logic               flip;
    int                 tests;
    int                 errors;
    int                 cen_cycles;
    int                 cen_count;
    int                 cenb_count;
    logic               cen_fail;
    logic               last_cen;

    s16b_main #(
        .CEN_NUM (CEN_NUM),
        .CEN_DEN (CEN_DEN)
    ) u_s16b_main (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .cab       (cab),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cs        (cs),
        .cpu_din   (cpu_din),
        .dtackn    (dtackn),
        .cpu_cen   (cpu_cen),
        .cpu_cenb  (cpu_cenb),
        .flip      (flip)
    );

    always #10 clk = ~clk;

    // cpu_cen and cpu_cenb alternate and never coincide
    always @(negedge clk) begin
        if (!rst) begin
            cen_cycles++;
            assert (!(cpu_cen && cpu_cenb)) else begin
                $display("cpu_cen and cpu_cenb were high in the same cycle");
                cen_fail = 1'b1;
            end
            if (cpu_cen) begin
                assert (cen_count + cenb_count == 0 || !last_cen) else begin
                    $display("two cpu_cen pulses came without a cpu_cenb between them");
                    cen_fail = 1'b1;
                end
                last_cen = 1'b1;
                cen_count++;
            end
            if (cpu_cenb) begin
                assert (cen_count + cenb_count == 0 || last_cen) else begin
                    $display("two cpu_cenb pulses came without a cpu_cen between them");
                    cen_fail = 1'b1;
                end
                last_cen = 1'b0;
                cenb_count++;
            end
        end
    end

    // Output bit i is taken from joystick bit joy_src[i]
    function automatic logic [7:0] joy_wiring(input logic [7:0] joy);
        int         joy_src [8];
        logic [7:0] res;
        joy_src = '{6, 4, 5, 7, 2, 3, 0, 1};
        for (int i = 0; i < 8; i++) begin
            res[i] = joy[joy_src[i]];
        end
        return res;
    endfunction

    function automatic logic [15:0] expected_word(input string tok);
        logic [15:0] v;
        v = 16'h0000;
        if (tok == "sys") begin
            v = {8'hff, 2'b11, cab.start[1], cab.start[0], cab.service, cab.test,
                 cab.coin[1], cab.coin[0]};
        end else if (tok == "joy1") begin
            v = {8'hff, joy_wiring(cab.joystick1)};
        end else if (tok == "joy2") begin
            v = {8'hff, joy_wiring(cab.joystick2)};
        end else if (tok == "dipa") begin
            v = {8'hff, cab.dip_a};
        end else if (tok == "dipb") begin
            v = {8'hff, cab.dip_b};
        end else begin
            void'($sscanf(tok, "%h", v));
        end
        return v;
    endfunction

    function automatic s16b_pkg::cs_t sel_to_cs(input string sel);
        s16b_pkg::cs_t c;
        c = '0;
        if (sel == "rom") c.rom = 1'b1;
        else if (sel == "ram") c.ram = 1'b1;
        else if (sel == "vram") c.vram = 1'b1;
        else if (sel == "chr") c.chr = 1'b1;
        else if (sel == "pal") c.pal = 1'b1;
        else if (sel == "obj") c.obj = 1'b1;
        else if (sel == "io") c.io = 1'b1;
        else if (sel == "map") c.map = 1'b1;
        return c;
    endfunction

    // Selected source returns the word, the others its complement
    task automatic drive_sources(input string sel, input logic [15:0] word);
        rom_data  = (sel == "rom" || sel == "none") ? word : ~word;
        ram_data  = (sel == "ram" || sel == "vram" || sel == "none") ? word : ~word;
        char_dout = (sel == "chr" || sel == "none") ? word : ~word;
        pal_dout  = (sel == "pal" || sel == "none") ? word : ~word;
        obj_dout  = (sel == "obj" || sel == "none") ? word : ~word;
    endtask

    task automatic randomize_cabinet();
        cab.joystick1 = 8'($urandom());
        cab.joystick2 = 8'($urandom());
        cab.start     = 2'($urandom());
        cab.coin      = 2'($urandom());
        cab.service   = 1'($urandom());
        cab.test      = 1'($urandom());
        cab.dip_a     = 8'($urandom());
        cab.dip_b     = 8'($urandom());
    endtask

    // One CPU bus cycle, entered and left 2 units after a rising edge
    task automatic bus_cycle(input string name, input string op, input logic [23:0] addr,
                             input logic [15:0] wdata, input int delay,
                             input string exp_tok, input string sel);
        s16b_pkg::cs_t cs_seen;
        logic          slow_prev;
        logic          ok_prev;
        logic          acked;
        logic          released;
        logic          fail;
        logic [15:0]   exp;
        int            slow_cnt;
        cs_seen   = '0;
        slow_prev = 1'b0;
        ok_prev   = 1'b0;
        acked     = 1'b0;
        released  = 1'b0;
        fail      = 1'b0;
        slow_cnt  = 0;
        drive_sources(sel, wdata);
        bus.addr = addr[23:1];
        bus.dout = wdata;
        bus.rnw  = op == "rd";
        bus.udsn = op == "wrl";
        bus.ldsn = op == "wru";
        bus.asn  = 1'b0;
        for (int n = 0; n < 500 && !acked; n++) begin
            @(posedge clk);
            #2;
            cs_seen = s16b_pkg::cs_t'(cs_seen | cs);
            assert (dtackn || !slow_prev || ok_prev) else begin
                $display("test %s: dtackn came while memory ok was low", name);
                fail = 1'b1;
            end
            if (!dtackn && cpu_cen) begin
                acked = 1'b1;
            end else begin
                // Memory ok rises delay cycles after a slow select
                slow_prev = cs.rom || cs.ram || cs.vram;
                slow_cnt  = slow_prev ? slow_cnt + 1 : 0;
                ok_prev   = slow_cnt > delay;
                rom_ok    = ok_prev;
                ram_ok    = ok_prev;
            end
        end
        assert (acked) else begin
            $display("test %s: dtackn never arrived within 500 cycles", name);
            fail = 1'b1;
        end
        if (acked && (exp_tok == "flip0" || exp_tok == "flip1")) begin
            assert (flip == (exp_tok == "flip1")) else begin
                $display("mismatch %s: expected flip %b actual %b", name,
                         exp_tok == "flip1", flip);
                fail = 1'b1;
            end
        end else if (acked && exp_tok != "-") begin
            exp = expected_word(exp_tok);
            assert (cpu_din == exp) else begin
                $display("mismatch %s: expected %h actual %h", name, exp, cpu_din);
                fail = 1'b1;
            end
        end
        assert (cs_seen == sel_to_cs(sel)) else begin
            $display("mismatch %s: expected cs %b actual %b", name, sel_to_cs(sel), cs_seen);
            fail = 1'b1;
        end
        bus.asn  = 1'b1;
        bus.udsn = 1'b1;
        bus.ldsn = 1'b1;
        bus.rnw  = 1'b1;
        for (int n = 0; n < 500 && !released; n++) begin
            @(posedge clk);
            #2;
            released = dtackn && cs == '0;
        end
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        assert (released) else begin
            $display("test %s: dtackn or a chip select stayed active after the strobe", name);
            fail = 1'b1;
        end
        tests++;
        if (fail) errors++;
        $display("test %s: %s", name, fail ? "FAIL" : "ok");
    endtask

    // Over the whole run cpu_cen comes CEN_NUM times per CEN_DEN clocks
    task automatic check_clock_enables();
        int   exp_cen;
        logic fail;
        exp_cen = cen_cycles * int'(CEN_NUM) / int'(CEN_DEN);
        fail    = cen_fail;
        assert (cen_count >= exp_cen - 1 && cen_count <= exp_cen + 1) else begin
            $display("mismatch clock_enables: expected cpu_cen count %0d actual %0d",
                     exp_cen, cen_count);
            fail = 1'b1;
        end
        tests++;
        if (fail) errors++;
        $display("test clock_enables: %s", fail ? "FAIL" : "ok");
    endtask

    initial begin
        int          fd;
        int          n;
        int          delay;
        string       line;
        string       name;
        string       op;
        string       exp_tok;
        string       sel;
        logic [23:0] addr;
        logic [15:0] wdata;
        void'($urandom(59509));
        clk        = 1'b0;
        rst        = 1'b1;
        bus        = '{addr: '0, dout: '0, rnw: 1'b1, udsn: 1'b1, ldsn: 1'b1, asn: 1'b1};
        cab        = '0;
        rom_data   = 16'h0000;
        rom_ok     = 1'b0;
        ram_data   = 16'h0000;
        ram_ok     = 1'b0;
        char_dout  = 16'h0000;
        pal_dout   = 16'h0000;
        obj_dout   = 16'h0000;
        tests      = 0;
        errors     = 0;
        cen_cycles = 0;
        cen_count  = 0;
        cenb_count = 0;
        cen_fail   = 1'b0;
        last_cen   = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        fd = $fopen("sim/s16b_stim.txt", "r");
        assert (fd != 0) else begin
            $display("stim file sim/s16b_stim.txt could not be opened");
            errors++;
        end
        while (fd != 0 && $fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %s %h %h %d %s %s", name, op, addr, wdata, delay,
                        exp_tok, sel);
            if (line.getc(0) == "#" || n <= 0) begin
                continue;
            end
            if (n != 7) begin
                $display("stim line not understood: %s", line);
                errors++;
            end else if (op == "cab") begin
                if (exp_tok == "rand") randomize_cabinet();
                tests++;
                $display("test %s: ok", name);
            end else begin
                bus_cycle(name, op, addr, wdata, delay, exp_tok, sel);
            end
        end
        if (fd != 0) $fclose(fd);
        check_clock_enables();
        if (tests == 0) errors++;
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sim/s16b_stim.txt
# name op byte_addr(hex) data(hex: write data, or memory word on reads) ok_delay expected sel
# expected: hex word, sys/joy1/joy2/dipa/dipb, flip0/flip1 or -; sel: chip select seen
rom_read_lo      rd   000100 a5c3 0 a5c3  rom
rom_read_hi      rd   07fffe 1e2d 0 1e2d  rom
unmapped_hold    rd   100000 5555 0 1e2d  none
map_ram_base     wr   ff000c 0010 0 -     map
map_ram_mask     wr   ff000e 00ff 0 -     map
map_vram_base    wr   ff0010 0040 0 -     map
map_vram_mask    wr   ff0012 00fe 0 -     map
map_obj_base     wr   ff0014 0044 0 -     map
map_obj_mask     wr   ff0016 00ff 0 -     map
map_pal_base     wr   ff0018 0084 0 -     map
map_pal_mask     wr   ff001a 00ff 0 -     map
map_io_base      wr   ff001c 00c4 0 -     map
map_io_mask      wr   ff001e 00ff 0 -     map
ram_read         rd   100010 3c3c 0 3c3c  ram
ram_slow         rd   10fffe 7e81 4 7e81  ram
vram_tile        rd   400200 0f0f 2 0f0f  vram
vram_text        rd   410200 f00f 0 f00f  chr
obj_read         rd   440020 1357 0 1357  obj
pal_read         rd   840040 2468 0 2468  pal
rom_slow         rd   000400 c0de 9 c0de  rom
ram_write_slow   wr   100020 beef 3 -     ram
cab_random       cab  000000 0000 0 rand  none
io_system        rd   c41000 0000 0 sys   io
io_joy1          rd   c41002 0000 0 joy1  io
io_joy2          rd   c41006 0000 0 joy2  io
io_unused        rd   c41004 0000 0 ffff  io
io_other         rd   c43000 0000 0 ffff  io
io_dip_a         rd   c42000 0000 0 dipa  io
io_dip_b         rd   c42002 0000 0 dipb  io
flip_set         wrl  c40000 0040 0 flip1 io
flip_upper_only  wru  c40000 0000 0 flip1 io
flip_clear       wrl  c40000 00bf 0 flip0 io
flip_set_again   wrl  c40000 ffff 0 flip1 io

//--- s16b_main.f
rtl/s16b_pkg.sv
rtl/s16b_mapper.sv
rtl/s16b_bus_decode.sv
rtl/s16b_cab_io.sv
rtl/s16b_dtack.sv
rtl/s16b_main.sv
sim/s16b_main_tb.sv

//--- Makefile
# Verilator flow for the S16B main bus testbench

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --assert --top-module s16b_main_tb \
		-f s16b_main.f -Mdir $(OBJ_DIR) -o s16b_main_sim

# Run and decide pass or fail from the log
run: compile
	./$(OBJ_DIR)/s16b_main_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
